/* Bender.yml */
package:
  name: hit_geometry

dependencies: {}

sources:
  - files:
      - logic/geom_pkg.sv
      - logic/pipe_pkg.sv
      - logic/hit_point_path.sv
      - logic/axial_projector.sv
      - logic/normal_combiner.sv
      - logic/hit_geometry_top.sv

  - target: test
    include_dirs:
      - tests
    files:
      - tests/hit_geometry_tb.sv

/* logic/axial_projector.sv */
module axial_projector
  import geom_pkg::*;
  import pipe_pkg::*;
(
  input  logic               aclk,
  input  logic               arst_n,
  input  logic               advance,
  input  logic               in_valid,
  input  logic [VEC_W-1:0]   ray_origin,
  input  logic [VEC_W-1:0]   ray_dir,
  input  logic [COORD_W-1:0] t,
  input  obj_word_t          obj,
  output logic [COORD_W-1:0] height,
  output logic [VEC_W-1:0]   axis,
  output logic               proj_valid
);

  logic [PATH_STAGES-1:0] vld_q;

  logic [VEC_W-1:0] base;
  logic [VEC_W-1:0] cyl_axis;
  logic [VEC_W-1:0] oc;       // O - C.

  logic [VEC_W-1:0]   oa_q;   // (O - C)_i * a_i.
  logic [VEC_W-1:0]   da_q;   // D_i * a_i.
  logic [COORD_W-1:0] t_q1;
  logic [COORD_W-1:0] t_q2;
  logic [VEC_W-1:0]   axis_q1;
  logic [VEC_W-1:0]   axis_q2;
  logic [COORD_W-1:0] dot_oc_q;
  logic [COORD_W-1:0] dot_da_q;

  // Cylinder view of the object word.
  assign base     = obj.cylinder.base;
  assign cyl_axis = obj.cylinder.axis;

  always_comb begin
    for (int i = 0; i < 3; i++) begin
      oc[i*COORD_W +: COORD_W] = ray_origin[i*COORD_W +: COORD_W] - base[i*COORD_W +: COORD_W];
    end
  end

  // --------------------------------------
  // Valid
  // --------------------------------------

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      vld_q <= '0;
    end else if (advance) begin
      vld_q <= {vld_q[PATH_STAGES-2:0], in_valid};
    end
  end

  assign proj_valid = vld_q[PATH_STAGES-1];

  // --------------------------------------
  // Products, dot sums, height
  // --------------------------------------

  always_ff @(posedge aclk) begin
    if (advance) begin
      for (int i = 0; i < 3; i++) begin
        oa_q[i*COORD_W +: COORD_W] <= fx_mul(oc[i*COORD_W +: COORD_W],
                                             cyl_axis[i*COORD_W +: COORD_W]);
        da_q[i*COORD_W +: COORD_W] <= fx_mul(ray_dir[i*COORD_W +: COORD_W],
                                             cyl_axis[i*COORD_W +: COORD_W]);
      end
      t_q1    <= t;
      axis_q1 <= cyl_axis;

      dot_oc_q <= oa_q[0 +: COORD_W] + oa_q[COORD_W +: COORD_W] + oa_q[2*COORD_W +: COORD_W];
      dot_da_q <= da_q[0 +: COORD_W] + da_q[COORD_W +: COORD_W] + da_q[2*COORD_W +: COORD_W];
      t_q2     <= t_q1;
      axis_q2  <= axis_q1;

      height <= dot_oc_q + fx_mul(t_q2, dot_da_q); // (O-C).a + t*(D.a).
      axis   <= axis_q2;
    end
  end

  a_valid_known: assert property (@(posedge aclk) disable iff (!arst_n)
    !$isunknown(proj_valid));

endmodule

/* logic/geom_pkg.sv */
package geom_pkg;

  // --------------------------------------
  // Fixed-point format
  // --------------------------------------

  localparam int FRAC_BITS = 16;          // Q16.16.
  localparam int COORD_W   = 32;          // One coordinate word.
  localparam int VEC_W     = 3 * COORD_W; // x in the low word, then y, then z.

  // Cylinders are only valid for an axial height below this.
  localparam logic signed [COORD_W-1:0] PIN_HEIGHT = 32'sh0003_0000; // 3.0.

  // --------------------------------------
  // Object word
  // --------------------------------------

  // The sphere center and the cylinder base occupy the same low vector,
  // so the hit-point path can take it without knowing the shape.
  typedef union packed {
    struct packed {
      logic [VEC_W-1:0] reserved; // Unused for spheres.
      logic [VEC_W-1:0] center;
    } sphere;
    struct packed {
      logic [VEC_W-1:0] axis;     // Unit length is assumed.
      logic [VEC_W-1:0] base;
    } cylinder;
  } obj_word_t;

  // --------------------------------------
  // Arithmetic
  // --------------------------------------

  // Full 64-bit signed product brought back to Q16.16.
  // The arithmetic shift rounds toward minus infinity.
  function automatic logic [COORD_W-1:0] fx_mul(
    input logic signed [COORD_W-1:0] a,
    input logic signed [COORD_W-1:0] b
  );
    logic signed [2*COORD_W-1:0] prod;
    logic signed [2*COORD_W-1:0] shifted;
    prod    = a * b;
    shifted = prod >>> FRAC_BITS;
    return shifted[COORD_W-1:0];
  endfunction

endpackage

/* logic/hit_geometry_top.sv */
module hit_geometry_top
  import geom_pkg::*;
  import pipe_pkg::*;
(
  input  logic               aclk,
  input  logic               arst_n,
  input  logic               in_valid,
  output logic               in_ready,
  input  logic [VEC_W-1:0]   ray_origin,
  input  logic [VEC_W-1:0]   ray_dir,
  input  logic [COORD_W-1:0] t,
  input  obj_word_t          obj,
  input  logic               is_cylinder,
  output logic               out_valid,
  input  logic               out_ready,
  output logic [VEC_W-1:0]   hit_point,
  output logic [VEC_W-1:0]   normal,
  output logic               invalid_cylinder_hit
);

  // --------------------------------------
  // Side path results
  // --------------------------------------

  logic               path_valid;
  logic [VEC_W-1:0]   pp_hit_point;
  logic [VEC_W-1:0]   pp_rel;
  logic               pp_is_cylinder;
  logic               proj_valid;
  logic [COORD_W-1:0] ap_height;
  logic [VEC_W-1:0]   ap_axis;

  // in_ready is the shared advance signal.
  hit_point_path u_hit_point_path (
    .aclk          (aclk),
    .arst_n        (arst_n),
    .advance       (in_ready),
    .in_valid      (in_valid),
    .ray_origin    (ray_origin),
    .ray_dir       (ray_dir),
    .t             (t),
    .obj           (obj),
    .is_cylinder   (is_cylinder),
    .path_valid    (path_valid),
    .hit_point     (pp_hit_point),
    .rel           (pp_rel),
    .is_cylinder_q (pp_is_cylinder)
  );

  axial_projector u_axial_projector (
    .aclk       (aclk),
    .arst_n     (arst_n),
    .advance    (in_ready),
    .in_valid   (in_valid),
    .ray_origin (ray_origin),
    .ray_dir    (ray_dir),
    .t          (t),
    .obj        (obj),
    .height     (ap_height),
    .axis       (ap_axis),
    .proj_valid (proj_valid)
  );

  normal_combiner u_normal_combiner (
    .aclk                 (aclk),
    .arst_n               (arst_n),
    .path_valid           (path_valid),
    .proj_valid           (proj_valid),
    .hit_point            (pp_hit_point),
    .rel                  (pp_rel),
    .is_cylinder          (pp_is_cylinder),
    .height               (ap_height),
    .axis                 (ap_axis),
    .out_ready            (out_ready),
    .advance              (in_ready),
    .out_valid            (out_valid),
    .hit_point_out        (hit_point),
    .normal               (normal),
    .invalid_cylinder_hit (invalid_cylinder_hit)
  );

  // An accepted item is presented after TOTAL_LATENCY edges without stalls.
  a_latency: assert property (@(posedge aclk) disable iff (!arst_n)
    (in_valid && in_ready) ##1 in_ready [* TOTAL_LATENCY-1] |=> out_valid);

endmodule

/* logic/hit_point_path.sv */
module hit_point_path
  import geom_pkg::*;
  import pipe_pkg::*;
(
  input  logic               aclk,
  input  logic               arst_n,
  input  logic               advance,
  input  logic               in_valid,
  input  logic [VEC_W-1:0]   ray_origin,
  input  logic [VEC_W-1:0]   ray_dir,
  input  logic [COORD_W-1:0] t,
  input  obj_word_t          obj,
  input  logic               is_cylinder,
  output logic               path_valid,
  output logic [VEC_W-1:0]   hit_point,
  output logic [VEC_W-1:0]   rel,
  output logic               is_cylinder_q
);

  logic [PATH_STAGES-1:0] vld_q;
  logic [PATH_STAGES-1:0] cyl_q;

  logic [VEC_W-1:0] td_q;   // t*D.
  logic [VEC_W-1:0] org_q;
  logic [VEC_W-1:0] ctr_q1;
  logic [VEC_W-1:0] ctr_q2;
  logic [VEC_W-1:0] p_q;

  // --------------------------------------
  // Valid and shape flag
  // --------------------------------------

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      vld_q <= '0;
    end else if (advance) begin
      vld_q <= {vld_q[PATH_STAGES-2:0], in_valid};
    end
  end

  always_ff @(posedge aclk) begin
    if (advance) begin
      cyl_q <= {cyl_q[PATH_STAGES-2:0], is_cylinder};
    end
  end

  assign path_valid    = vld_q[PATH_STAGES-1];
  assign is_cylinder_q = cyl_q[PATH_STAGES-1];

  // --------------------------------------
  // Datapath
  // --------------------------------------

  always_ff @(posedge aclk) begin
    if (advance) begin
      for (int i = 0; i < 3; i++) begin
        td_q[i*COORD_W +: COORD_W] <= fx_mul(t, ray_dir[i*COORD_W +: COORD_W]);
        p_q[i*COORD_W +: COORD_W]  <= org_q[i*COORD_W +: COORD_W] + td_q[i*COORD_W +: COORD_W];
        rel[i*COORD_W +: COORD_W]  <= p_q[i*COORD_W +: COORD_W] - ctr_q2[i*COORD_W +: COORD_W];
      end
      org_q     <= ray_origin;
      ctr_q1    <= obj.sphere.center; // Also the cylinder base.
      ctr_q2    <= ctr_q1;
      hit_point <= p_q;
    end
  end

  a_valid_known: assert property (@(posedge aclk) disable iff (!arst_n)
    !$isunknown(path_valid));

endmodule

/* logic/normal_combiner.sv */
module normal_combiner
  import geom_pkg::*;
  import pipe_pkg::*;
(
  input  logic               aclk,
  input  logic               arst_n,
  input  logic               path_valid,
  input  logic               proj_valid,
  input  logic [VEC_W-1:0]   hit_point,
  input  logic [VEC_W-1:0]   rel,
  input  logic               is_cylinder,
  input  logic [COORD_W-1:0] height,
  input  logic [VEC_W-1:0]   axis,
  input  logic               out_ready,
  output logic               advance,
  output logic               out_valid,
  output logic [VEC_W-1:0]   hit_point_out,
  output logic [VEC_W-1:0]   normal,
  output logic               invalid_cylinder_hit
);

  logic [COMBINE_STAGES-1:0] vld_q;

  logic [VEC_W-1:0] ha_q;   // h*a.
  logic [VEC_W-1:0] hp_q;
  logic [VEC_W-1:0] rel_q;
  logic             cyl_q;
  logic             flag_q;
  logic             below;
  logic             above;

  // --------------------------------------
  // Stall control
  // --------------------------------------

  assign out_valid = vld_q[COMBINE_STAGES-1];
  assign advance   = !out_valid || out_ready; // Whole pipeline moves together.

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      vld_q <= '0;
    end else if (advance) begin
      vld_q <= {vld_q[COMBINE_STAGES-2:0], path_valid};
    end
  end

  // --------------------------------------
  // Height check and normal
  // --------------------------------------

  assign below = height[COORD_W-1];
  assign above = $signed(height) >= PIN_HEIGHT;

  always_ff @(posedge aclk) begin
    if (advance) begin
      for (int i = 0; i < 3; i++) begin
        ha_q[i*COORD_W +: COORD_W] <= fx_mul(height, axis[i*COORD_W +: COORD_W]);
      end
      hp_q   <= hit_point;
      rel_q  <= rel;
      cyl_q  <= is_cylinder;
      flag_q <= is_cylinder && (below || above);
    end
  end

  always_ff @(posedge aclk) begin
    if (advance) begin
      for (int i = 0; i < 3; i++) begin
        normal[i*COORD_W +: COORD_W] <= cyl_q ?
          rel_q[i*COORD_W +: COORD_W] - ha_q[i*COORD_W +: COORD_W] :
          rel_q[i*COORD_W +: COORD_W]; // Sphere normal is P - C.
      end
      hit_point_out        <= hp_q;
      invalid_cylinder_hit <= flag_q;
    end
  end

  // Both side paths share one stall, so their valid bits must agree.
  a_paths_aligned: assert property (@(posedge aclk) disable iff (!arst_n)
    path_valid == proj_valid);

  a_out_stable: assert property (@(posedge aclk) disable iff (!arst_n)
    out_valid && !out_ready |=> out_valid && $stable(hit_point_out) &&
                                $stable(normal) && $stable(invalid_cylinder_hit));

endmodule

/* logic/pipe_pkg.sv */
package pipe_pkg;

  // --------------------------------------
  // Pipeline depths
  // --------------------------------------

  localparam int PATH_STAGES    = 3; // Hit-point path and axial projector.
  localparam int COMBINE_STAGES = 2; // Normal combiner including its output register.

  // Accept edge to output transfer edge with no back-pressure.
  localparam int TOTAL_LATENCY  = PATH_STAGES + COMBINE_STAGES;

endpackage

/* tests/hit_geometry_vectors.svh */
`ifndef HIT_GEOMETRY_VECTORS_SVH
`define HIT_GEOMETRY_VECTORS_SVH

// Each row holds origin, direction, t, shape flag, center or base, reserved or axis,
// axial height, expected hit point, expected normal and expected flag.
// Vectors, t and heights are given in quarters.
localparam int NUM_ROWS = 12;

task automatic load_vectors();
  add_row(quarter_vec(4, 8, 12), quarter_vec(0, 0, 4), 8, 1'b0,
          quarter_vec(4, 8, 24), quarter_vec(4, -4, 8), 0,
          quarter_vec(4, 8, 20), quarter_vec(0, 0, -4), 1'b0);
  add_row(quarter_vec(-8, 2, 4), quarter_vec(4, -4, 2), 6, 1'b0,
          quarter_vec(0, 0, 0), quarter_vec(0, 0, 0), 0,
          quarter_vec(-2, -4, 7), quarter_vec(-2, -4, 7), 1'b0);
  add_row(quarter_vec(0, 0, 0), quarter_vec(2, 2, -4), 16, 1'b0,
          quarter_vec(4, 4, -12), quarter_vec(0, 4, 0), 0,
          quarter_vec(8, 8, -16), quarter_vec(4, 4, -4), 1'b0);
  add_row(quarter_vec(4, 0, -4), quarter_vec(0, 0, 4), 10, 1'b1,
          quarter_vec(0, 0, 0), quarter_vec(0, 0, 4), 6,
          quarter_vec(4, 0, 6), quarter_vec(4, 0, 0), 1'b0);
  // Height exactly zero is still on the pin.
  add_row(quarter_vec(12, -4, 4), quarter_vec(-2, 4, 2), 8, 1'b1,
          quarter_vec(4, 4, 4), quarter_vec(0, 4, 0), 0,
          quarter_vec(8, 4, 8), quarter_vec(4, 0, 4), 1'b0);
  add_row(quarter_vec(4, 8, 0), quarter_vec(4, 0, -4), 8, 1'b1,
          quarter_vec(0, 0, 0), quarter_vec(4, 0, 0), 12,
          quarter_vec(12, 8, -8), quarter_vec(0, 8, -8), 1'b1);
  add_row(quarter_vec(2, 4, 4), quarter_vec(0, 0, 4), 2, 1'b1,
          quarter_vec(0, 4, 0), quarter_vec(0, 0, -4), -6,
          quarter_vec(2, 4, 6), quarter_vec(2, 0, 0), 1'b1);
  add_row(quarter_vec(0, 0, 0), quarter_vec(1, 4, 0), 16, 1'b1,
          quarter_vec(-4, -4, -4), quarter_vec(0, 4, 0), 20,
          quarter_vec(4, 16, 0), quarter_vec(8, 0, 4), 1'b1);
  add_row(quarter_vec(0, 0, 3), quarter_vec(4, 0, 4), 8, 1'b1,
          quarter_vec(0, 0, 0), quarter_vec(0, 0, 4), 11,
          quarter_vec(8, 0, 11), quarter_vec(8, 0, 0), 1'b0);
  // Sphere whose reserved half would read as an out-of-range cylinder.
  add_row(quarter_vec(0, 0, 0), quarter_vec(0, 0, 4), 40, 1'b0,
          quarter_vec(0, 0, 8), quarter_vec(0, 0, 4), 0,
          quarter_vec(0, 0, 40), quarter_vec(0, 0, 32), 1'b0);
  add_row(quarter_vec(4, 4, 4), quarter_vec(-4, 0, 2), 4, 1'b1,
          quarter_vec(8, 0, 0), quarter_vec(-4, 0, 0), 8,
          quarter_vec(0, 4, 6), quarter_vec(0, 4, 6), 1'b0);
  add_row(quarter_vec(1, -1, 0), quarter_vec(-2, 2, 8), 2, 1'b0,
          quarter_vec(-4, 4, 4), quarter_vec(0, 0, 0), 0,
          quarter_vec(0, 0, 4), quarter_vec(4, -4, 0), 1'b0);
endtask

`endif

/* tests/hit_geometry_tb.sv */
module hit_geometry_tb
  import geom_pkg::*;
  import pipe_pkg::*;
();

  logic               aclk;
  logic               arst_n;
  logic               in_valid;
  logic               in_ready;
  logic [VEC_W-1:0]   ray_origin;
  logic [VEC_W-1:0]   ray_dir;
  logic [COORD_W-1:0] t;
  obj_word_t          obj;
  logic               is_cylinder;
  logic               out_valid;
  logic               out_ready;
  logic [VEC_W-1:0]   hit_point;
  logic [VEC_W-1:0]   normal;
  logic               invalid_cylinder_hit;

  localparam int QUARTER = 1 << (FRAC_BITS - 2); // 0.25 in Q16.16.

  `include "hit_geometry_vectors.svh"

  localparam int TIMEOUT_CYCLES = 16 + 20 * NUM_ROWS + 50;

  logic [VEC_W-1:0]   row_origin [NUM_ROWS];
  logic [VEC_W-1:0]   row_dir    [NUM_ROWS];
  logic [COORD_W-1:0] row_t      [NUM_ROWS];
  obj_word_t          row_obj    [NUM_ROWS];
  logic               row_cyl    [NUM_ROWS];
  logic [VEC_W-1:0]   row_point  [NUM_ROWS];
  logic [VEC_W-1:0]   row_normal [NUM_ROWS];
  logic               row_flag   [NUM_ROWS];

  int               row_count = 0;
  int               cycle     = 0;
  int               received  = 0;
  int               pending_row [$];
  int               pending_cycle [$];
  int               out_idx;
  int               acc_cycle;
  logic             check_latency = 1'b1;
  logic             random_ready  = 1'b0;
  logic             holding       = 1'b0;
  logic [VEC_W-1:0] held_point;
  logic [VEC_W-1:0] held_normal;
  logic             held_flag;

  hit_geometry_top UUT (.*);

  // --------------------------------------
  // Helpers
  // --------------------------------------

  task automatic abort_run();
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string field, input logic [VEC_W-1:0] got,
                             input logic [VEC_W-1:0] exp);
    if (got !== exp) begin
      $display("error at %0t: %s is %h, expected %h", $time, field, got, exp);
      abort_run();
    end
  endtask

  function automatic logic [VEC_W-1:0] quarter_vec(input int x4, input int y4, input int z4);
    logic [COORD_W-1:0] x;
    logic [COORD_W-1:0] y;
    logic [COORD_W-1:0] z;
    x = x4 * QUARTER;
    y = y4 * QUARTER;
    z = z4 * QUARTER;
    return {z, y, x};
  endfunction

  task automatic add_row(input logic [VEC_W-1:0] origin, input logic [VEC_W-1:0] dir,
                         input int t4, input logic cyl, input logic [VEC_W-1:0] low,
                         input logic [VEC_W-1:0] high, input int h4,
                         input logic [VEC_W-1:0] exp_point, input logic [VEC_W-1:0] exp_normal,
                         input logic exp_flag);
    logic signed [COORD_W-1:0] h;
    h = h4 * QUARTER;
    if ((cyl && (h < 0 || h >= PIN_HEIGHT)) != exp_flag) begin
      $display("vector row %0d has a flag that does not match its height", row_count);
      abort_run();
    end
    row_origin[row_count]            = origin;
    row_dir[row_count]               = dir;
    row_t[row_count]                 = t4 * QUARTER;
    row_obj[row_count].cylinder.base = low;
    row_obj[row_count].cylinder.axis = high;
    row_cyl[row_count]               = cyl;
    row_point[row_count]             = exp_point;
    row_normal[row_count]            = exp_normal;
    row_flag[row_count]              = exp_flag;
    row_count++;
  endtask

  task automatic send_row(input int i);
    @(negedge aclk);
    ray_origin  = row_origin[i];
    ray_dir     = row_dir[i];
    t           = row_t[i];
    obj         = row_obj[i];
    is_cylinder = row_cyl[i];
    in_valid    = 1'b1;
    @(posedge aclk);
    while (!in_ready) @(posedge aclk);
    pending_row.push_back(i);
    pending_cycle.push_back(cycle);
  endtask

  // --------------------------------------
  // Clock, timeout, back-pressure
  // --------------------------------------

  initial begin
    aclk = 1'b0;
    forever #50 aclk = ~aclk;
  end

  always @(posedge aclk) begin
    cycle <= cycle + 1;
    if (cycle >= TIMEOUT_CYCLES) begin
      $display("timeout: only %0d of %0d results arrived", received, NUM_ROWS);
      abort_run();
    end
  end

  always @(negedge aclk) begin
    if (random_ready) out_ready = ($urandom % 4) != 0; // Ready about three cycles in four.
  end

  // --------------------------------------
  // Checker
  // --------------------------------------

  always @(posedge aclk) begin
    if (arst_n) begin
      if (holding) begin
        check_value("stalled out_valid", out_valid, 1'b1);
        check_value("stalled hit_point", hit_point, held_point);
        check_value("stalled normal", normal, held_normal);
        check_value("stalled flag", invalid_cylinder_hit, held_flag);
      end
      holding     = out_valid && !out_ready;
      held_point  = hit_point;
      held_normal = normal;
      held_flag   = invalid_cylinder_hit;
      if (out_valid && out_ready) begin
        if (pending_row.size() == 0) begin
          $display("an output appeared with no row in flight");
          abort_run();
        end
        out_idx   = pending_row.pop_front();
        acc_cycle = pending_cycle.pop_front();
        check_value($sformatf("row %0d hit_point", out_idx), hit_point, row_point[out_idx]);
        check_value($sformatf("row %0d normal", out_idx), normal, row_normal[out_idx]);
        check_value($sformatf("row %0d flag", out_idx), invalid_cylinder_hit,
                    row_flag[out_idx]);
        if (check_latency) begin
          check_value("latency", cycle - acc_cycle, TOTAL_LATENCY);
        end
        received = received + 1;
      end
    end
  end

  // --------------------------------------
  // Stimulus
  // --------------------------------------

  initial begin
    arst_n      = 1'b0;
    in_valid    = 1'b0;
    ray_origin  = '0;
    ray_dir     = '0;
    t           = '0;
    obj         = '0;
    is_cylinder = 1'b0;
    out_ready   = 1'b1;
    void'($urandom(32'hd36d));
    load_vectors();
    repeat (16) @(posedge aclk);
    @(negedge aclk);
    arst_n = 1'b1;
    @(negedge aclk);
    check_value("out_valid after reset", out_valid, 1'b0);
    check_value("in_ready after reset", in_ready, 1'b1);

    send_row(0); // Single item with out_ready held high.
    @(negedge aclk);
    in_valid = 1'b0;
    wait (received == 1);
    check_latency = 1'b0;
    random_ready  = 1'b1;

    for (int i = 1; i < NUM_ROWS; i++) begin
      send_row(i);
    end
    @(negedge aclk);
    in_valid = 1'b0;
    wait (received == NUM_ROWS);
    repeat (10) @(posedge aclk); // Any stray output would still be caught.
    $display("TEST OK");
    $finish;
  end

endmodule

/* verilog.f */
+incdir+tests
logic/geom_pkg.sv
logic/pipe_pkg.sv
logic/hit_point_path.sv
logic/axial_projector.sv
logic/normal_combiner.sv
logic/hit_geometry_top.sv
tests/hit_geometry_tb.sv
